// File: Bender.yml
package:
  name: sensor_emu

export_include_dirs:
  - .

sources:
  - sensor_emu_pkg.sv
  - sensor_emu_regs.sv
  - pattern_loop_store.sv
  - pattern_stream_seq.sv
  - sensor_emu_ctl.sv
  - target: test
    files:
      - tb_sensor_emu.sv

// File: pattern_loop_store.sv
/*
 * Looping pattern store
 * Entries are appended by loads and read back in order, wrapping to
 * the first entry after the last so the pattern repeats forever
 */
`timescale 1ns/1ps
`include "sensor_emu_defs.svh"

module pattern_loop_store (
   input  logic                     clk,
   input  logic                     resetn,

   // Append side
   input  logic                     load,
   input  sensor_emu_pkg::pattern_t load_data,

   // Control strobes
   input  logic                     clear,
   input  logic                     rewind,
   input  logic                     pop,

   // Read side
   output sensor_emu_pkg::pattern_t head,
   output sensor_emu_pkg::count_t   count
);

   import sensor_emu_pkg::*;

   localparam int ADDR_W = $clog2(`SE_DEPTH);

   // Pattern memory
   pattern_t mem [`SE_DEPTH];

   // Next entry to leave the store
   logic [ADDR_W-1:0] rd_ptr;

   // Store is at capacity
   logic full;

   // Read pointer sits on the last loaded entry
   logic last;

   logic append;

   assign full   = (count == count_t'(`SE_DEPTH));
   assign last   = ({1'b0, rd_ptr} == count - 1'b1);
   assign append = load & ~full & ~clear;

   // ========================================================================
   // Memory
   // ========================================================================

   // The count doubles as the write pointer
   always_ff @(posedge clk) begin
      if (append) begin
         mem[count[ADDR_W-1:0]] <= load_data;
      end
   end

   // Head is visible without a read cycle
   assign head = mem[rd_ptr];

   // ========================================================================
   // Pointers
   // ========================================================================
   always_ff @(posedge clk) begin
      if (!resetn || clear) begin
         // Empty store, reading from the top
         count  <= '0;
         rd_ptr <= '0;
      end else begin
         if (append) begin
            count <= count + 1'b1;
         end

         // Rewind wins over a pop in the same cycle
         if (rewind) begin
            rd_ptr <= '0;
         end else if (pop) begin
            rd_ptr <= last ? '0 : rd_ptr + 1'b1;
         end
      end
   end

endmodule

// File: pattern_stream_seq.sv
/*
 * Pattern stream sequencer
 * Picks the active store, counts the entries of each pass and
 * drives the valid/ready output stream
 */
`timescale 1ns/1ps

module pattern_stream_seq (
   input  logic                       clk,
   input  logic                       resetn,

   // From the register block
   input  sensor_emu_pkg::store_sel_t on_deck,
   input  logic                       hard_stop,

   // Store status
   input  sensor_emu_pkg::count_t     count_0,
   input  sensor_emu_pkg::count_t     count_1,
   input  sensor_emu_pkg::pattern_t   head_0,
   input  sensor_emu_pkg::pattern_t   head_1,

   // Store controls
   output logic                       pop_0,
   output logic                       pop_1,
   output logic                       rewind_0,
   output logic                       rewind_1,

   // Store now streaming
   output sensor_emu_pkg::store_sel_t active,

   // Output stream
   output sensor_emu_pkg::pattern_t   tdata,
   output logic                       tvalid,
   input  logic                       tready
);

   import sensor_emu_pkg::*;

   // Entries left in the current pass
   count_t pass_cnt;

   // Store and pass length picked from on_deck
   store_sel_t next_sel;
   count_t     next_cnt;

   logic fire;
   logic pass_end;

   // Valid drops in the same cycle as the stop strobe
   assign tvalid = (active != 2'b00) & ~hard_stop;
   assign fire   = tvalid & tready;
   assign tdata  = active[1] ? head_1 : head_0;

   // Each transfer advances the active store
   assign pop_0 = fire & active[0];
   assign pop_1 = fire & active[1];

   // A stopped store starts over from its first entry
   assign rewind_0 = hard_stop & active[0];
   assign rewind_1 = hard_stop & active[1];

   // Last entry of the pass leaves this cycle
   assign pass_end = fire & (pass_cnt == count_t'(1));

   // An on-deck store that was emptied is skipped
   always_comb begin
      next_sel = 2'b00;
      next_cnt = '0;
      if (on_deck == 2'b01 && count_0 != '0) begin
         next_sel = 2'b01;
         next_cnt = count_0;
      end else if (on_deck == 2'b10 && count_1 != '0) begin
         next_sel = 2'b10;
         next_cnt = count_1;
      end
   end

   // ========================================================================
   // Pass FSM
   // ========================================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         active   <= 2'b00;
         pass_cnt <= '0;
      end else if (hard_stop) begin
         active <= 2'b00;
      end else if (active == 2'b00 || pass_end) begin
         // Idle or end of pass, repeat, switch or go idle
         active   <= next_sel;
         pass_cnt <= next_cnt;
      end else if (fire) begin
         pass_cnt <= pass_cnt - 1'b1;
      end
   end

endmodule

// File: sensor_emu.f
+incdir+.
sensor_emu_pkg.sv
sensor_emu_regs.sv
pattern_loop_store.sv
pattern_stream_seq.sv
sensor_emu_ctl.sv
tb_sensor_emu.sv

// File: sensor_emu_ctl.sv
/*
 * Sensor emulator top level
 * Register block feeding two looping pattern stores, with a sequencer
 * streaming one store at a time
 */
`timescale 1ns/1ps

module sensor_emu_ctl (
   input  logic                     clk,
   input  logic                     resetn,

   // Host register port
   input  sensor_emu_pkg::reg_req_t req,
   output sensor_emu_pkg::reg_rsp_t rsp,

   // Pattern stream
   output sensor_emu_pkg::pattern_t tdata,
   output logic                     tvalid,
   input  logic                     tready
);

   import sensor_emu_pkg::*;

   // Register block to stores
   logic     load_0;
   logic     load_1;
   logic     clear_0;
   logic     clear_1;
   pattern_t load_data;

   // Store status
   count_t   count_0;
   count_t   count_1;
   pattern_t head_0;
   pattern_t head_1;

   // Sequencer to stores
   logic     pop_0;
   logic     pop_1;
   logic     rewind_0;
   logic     rewind_1;

   // Register block and sequencer handshake
   store_sel_t on_deck;
   store_sel_t active;
   logic       hard_stop;

   // ========================================================================
   // Command decode
   // ========================================================================
   sensor_emu_regs u_regs (
      .clk       (clk),
      .resetn    (resetn),
      .req       (req),
      .rsp       (rsp),
      .count_0   (count_0),
      .count_1   (count_1),
      .active    (active),
      .load_0    (load_0),
      .load_1    (load_1),
      .clear_0   (clear_0),
      .clear_1   (clear_1),
      .load_data (load_data),
      .on_deck   (on_deck),
      .hard_stop (hard_stop)
   );

   // ========================================================================
   // Pattern stores
   // ========================================================================
   pattern_loop_store u_store_0 (
      .clk       (clk),
      .resetn    (resetn),
      .load      (load_0),
      .load_data (load_data),
      .clear     (clear_0),
      .rewind    (rewind_0),
      .pop       (pop_0),
      .head      (head_0),
      .count     (count_0)
   );

   pattern_loop_store u_store_1 (
      .clk       (clk),
      .resetn    (resetn),
      .load      (load_1),
      .load_data (load_data),
      .clear     (clear_1),
      .rewind    (rewind_1),
      .pop       (pop_1),
      .head      (head_1),
      .count     (count_1)
   );

   // ========================================================================
   // Output sequencing
   // ========================================================================
   pattern_stream_seq u_seq (
      .clk       (clk),
      .resetn    (resetn),
      .on_deck   (on_deck),
      .hard_stop (hard_stop),
      .count_0   (count_0),
      .count_1   (count_1),
      .head_0    (head_0),
      .head_1    (head_1),
      .pop_0     (pop_0),
      .pop_1     (pop_1),
      .rewind_0  (rewind_0),
      .rewind_1  (rewind_1),
      .active    (active),
      .tdata     (tdata),
      .tvalid    (tvalid),
      .tready    (tready)
   );

endmodule

// File: sensor_emu_defs.svh
/*
 * Sensor emulator constants
 * Pattern sizing, register indices and the module revision
 */
`ifndef SENSOR_EMU_DEFS_SVH
`define SENSOR_EMU_DEFS_SVH

// ==========================================================================
// Pattern store sizing
// ==========================================================================

// Width of one pattern entry
`define SE_PATTERN_W 32

// Entries held by each store
`define SE_DEPTH 256

// Entry count, wide enough for an empty and a completely full store
`define SE_COUNT_W 9

// ==========================================================================
// Register map
// ==========================================================================

`define SE_REG_REV       3'd0
`define SE_REG_FIFO_CTL  3'd1
`define SE_REG_LOAD_F0   3'd2
`define SE_REG_LOAD_F1   3'd3
`define SE_REG_START     3'd4
`define SE_REG_HARD_STOP 3'd5

// Bumped whenever the register map changes
`define SE_MODULE_REV 32'd1

`endif

// File: sensor_emu_pkg.sv
/*
 * Sensor emulator types
 * Pattern payload, entry counts, store masks and the host register port
 */
`include "sensor_emu_defs.svh"

package sensor_emu_pkg;

   // One pattern entry
   typedef logic [`SE_PATTERN_W-1:0] pattern_t;

   // Number of entries in a store
   typedef logic [`SE_COUNT_W-1:0] count_t;

   // Store mask
   // Bit 0 is store 0, bit 1 is store 1, zero means no store
   typedef logic [1:0] store_sel_t;

   // ========================================================================
   // Host register port
   // ========================================================================

   // Command from the host, each strobe high for a single cycle
   typedef struct packed {
      logic       wr;
      logic       rd;
      logic [2:0] idx;
      pattern_t   wdata;
   } reg_req_t;

   // Response, valid for one cycle after every strobe
   typedef struct packed {
      logic     valid;
      logic     err;
      pattern_t rdata;
   } reg_rsp_t;

endpackage

// File: sensor_emu_regs.sv
/*
 * Sensor emulator register block
 * Decodes host writes and reads, drives store loads and clears
 * and holds the on-deck store selection
 */
`timescale 1ns/1ps
`include "sensor_emu_defs.svh"

module sensor_emu_regs (
   input  logic                       clk,
   input  logic                       resetn,

   // Host port
   input  sensor_emu_pkg::reg_req_t   req,
   output sensor_emu_pkg::reg_rsp_t   rsp,

   // Status from the stores and the sequencer
   input  sensor_emu_pkg::count_t     count_0,
   input  sensor_emu_pkg::count_t     count_1,
   input  sensor_emu_pkg::store_sel_t active,

   // Store controls
   output logic                       load_0,
   output logic                       load_1,
   output logic                       clear_0,
   output logic                       clear_1,
   output sensor_emu_pkg::pattern_t   load_data,

   // Sequencer controls
   output sensor_emu_pkg::store_sel_t on_deck,
   output logic                       hard_stop
);

   import sensor_emu_pkg::*;

   // Store mask carried by a START write
   store_sel_t start_sel;

   // Read data selected by the current index
   pattern_t read_word;

   assign start_sel = req.wdata[1:0];

   // ========================================================================
   // Write decode
   // ========================================================================
   always_ff @(posedge clk) begin
      // Store and stop controls are single cycle strobes
      load_0    <= 1'b0;
      load_1    <= 1'b0;
      clear_0   <= 1'b0;
      clear_1   <= 1'b0;
      hard_stop <= 1'b0;

      if (!resetn) begin
         on_deck <= 2'b00;
      end else if (req.wr) begin
         case (req.idx)
            `SE_REG_FIFO_CTL: begin
               // Bit 0 empties store 0 and bit 1 empties store 1
               // A streaming store keeps its contents
               clear_0 <= req.wdata[0] & ~active[0];
               clear_1 <= req.wdata[1] & ~active[1];
            end

            // Loads into the streaming store are dropped
            `SE_REG_LOAD_F0: load_0 <= ~active[0];
            `SE_REG_LOAD_F1: load_1 <= ~active[1];

            `SE_REG_START: begin
               case (start_sel)
                  // Let the stream run out after the current pass
                  2'b00: on_deck <= 2'b00;
                  // Only a store holding a pattern can be queued
                  2'b01: if (count_0 != '0) on_deck <= 2'b01;
                  2'b10: if (count_1 != '0) on_deck <= 2'b10;
                  // Both stores at once is refused
                  default: ;
               endcase
            end

            `SE_REG_HARD_STOP: begin
               // Nothing queued behind the stop
               on_deck   <= 2'b00;
               hard_stop <= 1'b1;
            end

            default: ;
         endcase
      end
   end

   // Entry handed to the store along with its load strobe
   always_ff @(posedge clk) begin
      if (req.wr && (req.idx == `SE_REG_LOAD_F0 || req.idx == `SE_REG_LOAD_F1)) begin
         load_data <= req.wdata;
      end
   end

   // ========================================================================
   // Read path
   // ========================================================================
   always_comb begin
      case (req.idx)
         `SE_REG_REV:     read_word = `SE_MODULE_REV;
         `SE_REG_LOAD_F0: read_word = pattern_t'(count_0);
         `SE_REG_LOAD_F1: read_word = pattern_t'(count_1);
         `SE_REG_START:   read_word = pattern_t'(active);
         // FIFO_CTL and HARD_STOP read back as zero
         default:         read_word = '0;
      endcase
   end

   // One response per strobe, one cycle later
   always_ff @(posedge clk) begin
      if (!resetn) begin
         rsp <= '0;
      end else begin
         rsp.valid <= req.wr | req.rd;
         // Indices past HARD_STOP are not decoded
         rsp.err   <= (req.wr | req.rd) & (req.idx > `SE_REG_HARD_STOP);
         rsp.rdata <= req.rd ? read_word : '0;
      end
   end

endmodule

// File: sensor_emu_vectors.txt
# W idx data (hex) write | R idx data err (hex) read and expect
# S n collect n words | I n tvalid low n cycles | T v wait for tvalid == v (decimal)
I 4
R 0 00000001 0
R 2 00000000 0
R 3 00000000 0
W 2 a5a50001
W 2 a5a50002
W 2 a5a50003
W 2 a5a50004
W 2 a5a50005
W 4 00000001
S 15
R 4 00000001 0
W 3 5eed0010
W 3 5eed0011
W 3 5eed0012
S 2
W 4 00000002
S 6
R 4 00000002 0
S 1
W 4 00000000
S 2
I 20
W 4 00000001
S 2
W 5 00000000
T 0
W 4 00000001
S 3
R 2 00000005 0
W 2 deadbeef
R 2 00000005 0
W 1 00000001
R 2 00000005 0
W 1 00000002
R 3 00000000 0
W 4 00000002
W 4 00000003
R 4 00000001 0
R 7 00000000 1
S 7

// File: tb_sensor_emu.sv
/*
 * Sensor emulator testbench
 * Replays the command vectors against the DUT and checks the stream
 * against a model of the two looping stores and the sequencer
 */
`timescale 1ns/1ps
`include "sensor_emu_defs.svh"

module tb_sensor_emu;

   import sensor_emu_pkg::*;

   // Cycles any single wait may take
   localparam int TIMEOUT = 200;

   logic     clk;
   logic     resetn;
   reg_req_t req;
   reg_rsp_t rsp;
   pattern_t tdata;
   logic     tvalid;
   logic     tready;

   // Back-pressure generator state
   logic [31:0] rnd_state;

   // ========================================================================
   // Reference model, store index or -1 for none
   // ========================================================================
   pattern_t model_mem [2][`SE_DEPTH];
   int       model_cnt [2];
   int       model_ptr [2];
   int       model_active;
   int       model_deck;
   int       model_left;

   sensor_emu_ctl u_dut (
      .clk    (clk),
      .resetn (resetn),
      .req    (req),
      .rsp    (rsp),
      .tdata  (tdata),
      .tvalid (tvalid),
      .tready (tready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) begin
         abort_run($sformatf("ERR %0t ns %s got %h expected %h", $time, name, got, want));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Repeat, switch or go idle from the on-deck store
   function automatic void model_pick();
      if (model_deck >= 0 && model_cnt[model_deck] > 0) begin
         model_active = model_deck;
         model_left   = model_cnt[model_deck];
      end else begin
         model_active = -1;
      end
   endfunction

   function automatic void model_write(input logic [2:0] idx, input logic [31:0] data);
      int s;
      case (idx)
         `SE_REG_FIFO_CTL: begin
            // Streaming store is never cleared
            for (s = 0; s < 2; s++) begin
               if (data[s] && model_active != s) begin
                  model_cnt[s] = 0;
                  model_ptr[s] = 0;
               end
            end
         end
         `SE_REG_LOAD_F0, `SE_REG_LOAD_F1: begin
            s = (idx == `SE_REG_LOAD_F1);
            if (model_active != s && model_cnt[s] < `SE_DEPTH) begin
               model_mem[s][model_cnt[s]] = data;
               model_cnt[s]++;
            end
         end
         `SE_REG_START: begin
            // Both stores, or an empty one, leave on_deck alone
            if (data[1:0] == 2'b00) begin
               model_deck = -1;
            end else if (data[1:0] == 2'b01 && model_cnt[0] > 0) begin
               model_deck = 0;
            end else if (data[1:0] == 2'b10 && model_cnt[1] > 0) begin
               model_deck = 1;
            end
         end
         `SE_REG_HARD_STOP: begin
            if (model_active >= 0) begin
               model_ptr[model_active] = 0;
            end
            model_active = -1;
            model_deck   = -1;
         end
         default: ;
      endcase
      // An idle sequencer picks up whatever is on deck
      if (model_active < 0) begin
         model_pick();
      end
   endfunction

   // Next word the stream must deliver
   task automatic model_pop(output pattern_t word);
      if (model_active < 0) begin
         abort_run("Stream delivered a word while no store should be active");
      end else begin
         word = model_mem[model_active][model_ptr[model_active]];
         model_ptr[model_active] = (model_ptr[model_active] + 1) % model_cnt[model_active];
         model_left--;
         if (model_left == 0) begin
            model_pick();
         end
      end
   endtask

   // ========================================================================
   // Register port
   // ========================================================================
   task automatic reg_access(input logic wr, input logic [2:0] idx,
                             input logic [31:0] data, output reg_rsp_t resp);
      int waited;
      waited = 0;
      @(posedge clk);
      req <= '{wr: wr, rd: ~wr, idx: idx, wdata: wr ? data : '0};
      @(posedge clk);
      req <= '0;
      @(negedge clk);
      while (!rsp.valid) begin
         if (waited == TIMEOUT) begin
            abort_run("No register response arrived within the timeout");
         end
         waited++;
         @(negedge clk);
      end
      resp = rsp;
   endtask

   task automatic write_reg(input logic [2:0] idx, input logic [31:0] data);
      reg_rsp_t resp;
      reg_access(1'b1, idx, data, resp);
      check_value("rsp.err", resp.err, 1'b0);
      model_write(idx, data);
   endtask

   task automatic read_reg(input logic [2:0] idx, input logic [31:0] want,
                           input logic want_err);
      reg_rsp_t resp;
      reg_access(1'b0, idx, '0, resp);
      check_value("rsp.rdata", resp.rdata, want);
      check_value("rsp.err", resp.err, want_err);
   endtask

   // ========================================================================
   // Stream side
   // ========================================================================
   task automatic collect_stream(input int n);
      int       got;
      int       idle;
      logic     holding;
      pattern_t held;
      pattern_t want;
      got     = 0;
      idle    = 0;
      holding = 1'b0;
      while (got < n) begin
         @(posedge clk);
         rnd_state = xorshift32(rnd_state);
         tready <= rnd_state[7];
         @(negedge clk);
         // A stalled word must not change
         if (holding && tvalid) begin
            check_value("tdata (stalled)", tdata, held);
         end
         holding = tvalid & ~tready;
         held    = tdata;
         if (tvalid && tready) begin
            model_pop(want);
            check_value("tdata", tdata, want);
            got++;
            idle = 0;
         end else if (idle == TIMEOUT) begin
            abort_run($sformatf("Stream stalled after %0d of %0d words", got, n));
         end else begin
            idle++;
         end
      end
      @(posedge clk);
      tready <= 1'b0;
   endtask

   task automatic check_idle(input int n);
      repeat (n) begin
         @(negedge clk);
         check_value("tvalid", tvalid, 1'b0);
      end
   endtask

   task automatic wait_valid(input logic v);
      int waited;
      waited = 0;
      @(negedge clk);
      while (tvalid !== v) begin
         if (waited == TIMEOUT) begin
            abort_run($sformatf("tvalid did not reach %0d within the timeout", v));
         end
         waited++;
         @(negedge clk);
      end
   endtask

   // ========================================================================
   // Vector replay
   // ========================================================================
   initial begin
      int          fd;
      int          fields;
      string       line;
      byte         op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      resetn       = 1'b0;
      req          = '0;
      tready       = 1'b0;
      rnd_state    = 32'd27857;
      model_active = -1;
      model_deck   = -1;
      model_left   = 0;
      for (int s = 0; s < 2; s++) begin
         model_cnt[s] = 0;
         model_ptr[s] = 0;
      end
      repeat (8) @(posedge clk);
      resetn <= 1'b1;

      fd = $fopen("sensor_emu_vectors.txt", "r");
      if (fd == 0) begin
         abort_run("Cannot open sensor_emu_vectors.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         fields = $fgets(line, fd);
         // Skip comments and blank lines
         if (fields == 0 || line.len() < 2 || line[0] == "#") begin
            continue;
         end
         op = line[0];
         case (op)
            "W": fields = $sscanf(line, "%c %h %h", op, a, b);
            "R": fields = $sscanf(line, "%c %h %h %h", op, a, b, c);
            default: fields = $sscanf(line, "%c %d", op, a);
         endcase
         if (fields < 2) begin
            abort_run($sformatf("Malformed vector line: %s", line));
         end
         case (op)
            "W": write_reg(a[2:0], b);
            "R": read_reg(a[2:0], b, c[0]);
            "S": collect_stream(a);
            "I": check_idle(a);
            "T": wait_valid(a[0]);
            default: abort_run($sformatf("Unknown vector command: %s", line));
         endcase
      end
      $fclose(fd);
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule
